//--- design/calc_pkg.sv
package calc_pkg;

  // Number of completion stages, stage 3 is writeback
  localparam int comp_stages_lp = 4;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [4:0]  shamt_t;

  typedef enum logic [3:0]
  {
    OP_ADD = 4'h0
    , OP_SUB = 4'h1
    , OP_AND = 4'h2
    , OP_OR  = 4'h3
    , OP_XOR = 4'h4
    , OP_SLL = 4'h5
    , OP_SRL = 4'h6
    , OP_SLT = 4'h7
    , OP_MUL = 4'h8
  } op_e;

  typedef struct packed
  {
    logic      v;
    op_e       op;
    logic      rs1_r_v;
    logic      rs2_r_v;
    logic      rd_w_v;
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
  } dispatch_pkt_t;

  typedef struct packed
  {
    logic      w_v;
    reg_addr_t rd_addr;
    word_t     rd_data;
  } wb_pkt_t;

  typedef struct packed
  {
    logic  v;
    word_t data;
  } pipe_result_t;

  // Index 0 is the youngest instruction
  typedef wb_pkt_t [comp_stages_lp-1:0] comp_stage_t;
  typedef word_t   [comp_stages_lp-1:0] fwd_data_t;

endpackage

//--- design/calc_issue.sv
`timescale 1ns/1ps

module calc_issue
  (input                              clk_i
   , input                            reset_i
   , input                            flush_i

   , input calc_pkg::dispatch_pkt_t   dispatch_pkt_i
   , input calc_pkg::comp_stage_t     comp_stage_r_i
   , input calc_pkg::fwd_data_t       fwd_data_i

   , output calc_pkg::dispatch_pkt_t  reservation_o
   );

  function automatic calc_pkg::word_t bypass_operand
    (input calc_pkg::reg_addr_t     addr
     , input logic                  r_v
     , input calc_pkg::word_t       rf_data
     , input calc_pkg::comp_stage_t stages
     , input calc_pkg::fwd_data_t   fwd
     );
    calc_pkg::word_t data;
    data = rf_data;
    // Oldest first, so a younger match overrides
    for (int i = calc_pkg::comp_stages_lp-1; i >= 0; i--)
    begin
      if (r_v && stages[i].w_v && (stages[i].rd_addr == addr))
      begin
        data = fwd[i];
      end
    end
    return data;
  endfunction

  calc_pkg::dispatch_pkt_t reservation_n;
  calc_pkg::dispatch_pkt_t reservation_r;

  always_comb
  begin
    reservation_n          = dispatch_pkt_i;
    reservation_n.v        = dispatch_pkt_i.v & ~flush_i;
    reservation_n.rs1_data = bypass_operand(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1_r_v,
                                            dispatch_pkt_i.rs1_data, comp_stage_r_i, fwd_data_i);
    reservation_n.rs2_data = bypass_operand(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2_r_v,
                                            dispatch_pkt_i.rs2_data, comp_stage_r_i, fwd_data_i);
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      reservation_r.v <= 1'b0;
    end
    else
    begin
      reservation_r <= reservation_n;
    end
  end

  assign reservation_o = reservation_r;

endmodule

//--- design/calc_pipe_int.sv
`timescale 1ns/1ps

module calc_pipe_int
  (input calc_pkg::dispatch_pkt_t    reservation_i
   , output calc_pkg::pipe_result_t  int_result_o
   );

  calc_pkg::word_t  src1;
  calc_pkg::word_t  src2;
  calc_pkg::shamt_t shamt;
  calc_pkg::word_t  result;

  assign src1  = reservation_i.rs1_data;
  assign src2  = reservation_i.rs2_data;
  assign shamt = src2[4:0];

  always_comb
  begin
    case (reservation_i.op)
      calc_pkg::OP_ADD:
        result = src1 + src2;
      calc_pkg::OP_SUB:
        result = src1 - src2;
      calc_pkg::OP_AND:
        result = src1 & src2;
      calc_pkg::OP_OR:
        result = src1 | src2;
      calc_pkg::OP_XOR:
        result = src1 ^ src2;
      calc_pkg::OP_SLL:
        result = src1 << shamt;
      calc_pkg::OP_SRL:
        result = src1 >> shamt;
      calc_pkg::OP_SLT:
        result = calc_pkg::word_t'($signed(src1) < $signed(src2));
      default:
        result = '0;
    endcase
  end

  // Multiplies are handled by the mul pipe
  assign int_result_o.v    = reservation_i.v & (reservation_i.op != calc_pkg::OP_MUL);
  assign int_result_o.data = result;

endmodule

//--- design/calc_pipe_mul.sv
`timescale 1ns/1ps

module calc_pipe_mul
  (input                              clk_i
   , input                            reset_i
   , input                            flush_i

   , input calc_pkg::dispatch_pkt_t   reservation_i
   , output calc_pkg::pipe_result_t   mul_result_o
   );

  typedef struct packed
  {
    logic            v;
    calc_pkg::word_t src1;
    calc_pkg::word_t src2;
  } mul_ops_t;

  mul_ops_t               ops_n;
  mul_ops_t               ops_r;
  calc_pkg::pipe_result_t prod_n;
  calc_pkg::pipe_result_t prod_r;

  assign ops_n.v    = reservation_i.v & (reservation_i.op == calc_pkg::OP_MUL) & ~flush_i;
  assign ops_n.src1 = reservation_i.rs1_data;
  assign ops_n.src2 = reservation_i.rs2_data;

  // Low half of the product only
  assign prod_n.v    = ops_r.v & ~flush_i;
  assign prod_n.data = ops_r.src1 * ops_r.src2;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      ops_r.v  <= 1'b0;
      prod_r.v <= 1'b0;
    end
    else
    begin
      ops_r  <= ops_n;
      prod_r <= prod_n;
    end
  end

  assign mul_result_o = prod_r;

endmodule

//--- design/calc_completion.sv
`timescale 1ns/1ps

module calc_completion
  (input                              clk_i
   , input                            reset_i
   , input                            flush_i

   , input calc_pkg::dispatch_pkt_t   reservation_i
   , input calc_pkg::pipe_result_t    int_result_i
   , input calc_pkg::pipe_result_t    mul_result_i

   , output calc_pkg::comp_stage_t    comp_stage_r_o
   , output calc_pkg::fwd_data_t      fwd_data_o
   , output calc_pkg::wb_pkt_t        wb_pkt_o
   );

  localparam int last_lp = calc_pkg::comp_stages_lp - 1;

  // Stage 0 is the reservation itself, later stages are registered
  calc_pkg::wb_pkt_t                 stage0;
  calc_pkg::wb_pkt_t [last_lp:1]     stage_n;
  calc_pkg::wb_pkt_t [last_lp:1]     stage_r;
  calc_pkg::comp_stage_t             comp_stage_r;

  assign stage0.w_v     = reservation_i.v & reservation_i.rd_w_v;
  assign stage0.rd_addr = reservation_i.rd_addr;
  assign stage0.rd_data = '0;

  assign comp_stage_r = {stage_r, stage0};

  // Latencies are static, so at most one pipe finishes per stage
  always_comb
  begin
    for (int i = 1; i <= last_lp; i++)
    begin
      stage_n[i] = comp_stage_r[i-1];
    end
    stage_n[1].rd_data |= int_result_i.v ? int_result_i.data : '0;
    stage_n[3].rd_data |= mul_result_i.v ? mul_result_i.data : '0;

    // Flush kills everything short of writeback
    for (int i = 1; i <= last_lp; i++)
    begin
      stage_n[i].w_v &= ~flush_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 1; i <= last_lp; i++)
      begin
        stage_r[i].w_v <= 1'b0;
      end
    end
    else
    begin
      stage_r <= stage_n;
    end
  end

  always_comb
  begin
    for (int i = 0; i < last_lp; i++)
    begin
      fwd_data_o[i] = stage_n[i+1].rd_data;
    end
    fwd_data_o[last_lp] = stage_r[last_lp].rd_data;
  end

  assign comp_stage_r_o = comp_stage_r;
  assign wb_pkt_o       = stage_r[last_lp];

endmodule

//--- design/calc_top.sv
`timescale 1ns/1ps

module calc_top
  (input                              clk_i
   , input                            reset_i
   , input                            flush_i

   , input calc_pkg::dispatch_pkt_t   dispatch_pkt_i
   , output calc_pkg::wb_pkt_t        wb_pkt_o
   );

  calc_pkg::dispatch_pkt_t reservation;
  calc_pkg::pipe_result_t  int_result;
  calc_pkg::pipe_result_t  mul_result;
  calc_pkg::comp_stage_t   comp_stage_r;
  calc_pkg::fwd_data_t     fwd_data;

  calc_issue issue
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(flush_i)
     ,.dispatch_pkt_i(dispatch_pkt_i)
     ,.comp_stage_r_i(comp_stage_r)
     ,.fwd_data_i(fwd_data)
     ,.reservation_o(reservation)
     );

  // ALU, result in the reservation cycle
  calc_pipe_int pipe_int
    (.reservation_i(reservation)
     ,.int_result_o(int_result)
     );

  // Multiplier, two more cycles
  calc_pipe_mul pipe_mul
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(flush_i)
     ,.reservation_i(reservation)
     ,.mul_result_o(mul_result)
     );

  calc_completion completion
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(flush_i)
     ,.reservation_i(reservation)
     ,.int_result_i(int_result)
     ,.mul_result_i(mul_result)
     ,.comp_stage_r_o(comp_stage_r)
     ,.fwd_data_o(fwd_data)
     ,.wb_pkt_o(wb_pkt_o)
     );

endmodule

//--- dv/calc_tb.sv
`timescale 1ns/1ps

module calc_tb;

  localparam int clk_period_lp   = 40;
  localparam int drive_delay_lp  = 2;
  localparam int reset_cycles_lp = 10;
  localparam int stim_depth_lp   = 64;
  localparam int wb_latency_lp   = 4;

  // One expected writeback tagged with its dispatch cycle
  typedef struct packed
  {
    int                  disp;
    calc_pkg::reg_addr_t rd_addr;
    calc_pkg::word_t     rd_data;
  } wb_expect_t;

  logic                    clk_i;
  logic                    reset_i;
  logic                    flush_i;
  calc_pkg::dispatch_pkt_t dispatch_pkt_i;
  calc_pkg::wb_pkt_t       wb_pkt_o;

  logic [79:0]     stim_mem [0:stim_depth_lp-1];
  calc_pkg::word_t model_rf [0:31];
  wb_expect_t      expect_q [$];

  int   cycle;
  int   num_lines;
  int   timeout_limit;
  int   run_cycles;
  logic running;

  calc_top uut
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(flush_i)
     ,.dispatch_pkt_i(dispatch_pkt_i)
     ,.wb_pkt_o(wb_pkt_o)
     );

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period_lp/2) clk_i = ~clk_i;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic check_wb
    (input string name, input calc_pkg::wb_pkt_t got, input calc_pkg::wb_pkt_t exp);
    if (got.w_v !== exp.w_v)
    begin
      stop_run($sformatf("Fail %s.w_v got %h expected %h in cycle %0d",
                         name, got.w_v, exp.w_v, cycle));
    end
    else if (exp.w_v && (got.rd_addr !== exp.rd_addr))
    begin
      stop_run($sformatf("Fail %s.rd_addr got %h expected %h in cycle %0d",
                         name, got.rd_addr, exp.rd_addr, cycle));
    end
  endtask

  task automatic check_word
    (input string name, input calc_pkg::word_t got, input calc_pkg::word_t exp);
    if (got !== exp)
    begin
      stop_run($sformatf("Fail %s got %h expected %h in cycle %0d", name, got, exp, cycle));
    end
  endtask

  // Register data comes from the model file and is stale for producers in flight
  task automatic drive_line(input logic [79:0] line);
    logic [3:0]              kind;
    calc_pkg::dispatch_pkt_t pkt;
    wb_expect_t              entry;
    kind         = line[79:76];
    pkt          = '0;
    pkt.v        = (kind == 4'h2) || (kind == 4'h3);
    pkt.op       = calc_pkg::op_e'(line[71:68]);
    pkt.rs1_r_v  = line[64];
    pkt.rs2_r_v  = line[60];
    pkt.rd_w_v   = line[56];
    pkt.rd_addr  = line[52:48];
    pkt.rs1_addr = line[44:40];
    pkt.rs2_addr = line[36:32];
    pkt.rs1_data = model_rf[pkt.rs1_addr];
    pkt.rs2_data = model_rf[pkt.rs2_addr];
    dispatch_pkt_i = pkt;
    flush_i        = line[72];
    if (line[72])
    begin
      // Flush kills the three youngest in flight
      // The dispatch of the flush cycle is never queued
      while ((expect_q.size() > 0) && (expect_q[$].disp >= cycle - 3))
      begin
        void'(expect_q.pop_back());
      end
    end
    else if (pkt.v && pkt.rd_w_v)
    begin
      entry.disp    = cycle;
      entry.rd_addr = pkt.rd_addr;
      entry.rd_data = line[31:0];
      expect_q.push_back(entry);
    end
  endtask

  task automatic check_cycle;
    calc_pkg::wb_pkt_t exp;
    exp = '0;
    if ((expect_q.size() > 0) && (expect_q[0].disp + wb_latency_lp == cycle))
    begin
      exp.w_v     = 1'b1;
      exp.rd_addr = expect_q[0].rd_addr;
      exp.rd_data = expect_q[0].rd_data;
      check_wb("wb_pkt_o", wb_pkt_o, exp);
      check_word("wb_pkt_o.rd_data", wb_pkt_o.rd_data, exp.rd_data);
      model_rf[exp.rd_addr] = exp.rd_data;
      void'(expect_q.pop_front());
    end
    else
    begin
      check_wb("wb_pkt_o", wb_pkt_o, exp);
    end
  endtask

  task automatic next_cycle;
    @(posedge clk_i);
    #(drive_delay_lp);
    cycle++;
  endtask

  initial
  begin
    reset_i        = 1'b1;
    flush_i        = 1'b0;
    dispatch_pkt_i = '0;
    running        = 1'b0;
    cycle          = 0;
    for (int i = 0; i < 32; i++)
    begin
      model_rf[i] = '0;
    end
    $readmemh("dv/calc_stimulus.txt", stim_mem);
    num_lines = 0;
    while ((num_lines < stim_depth_lp) && (stim_mem[num_lines][79:76] !== 4'hF))
    begin
      num_lines++;
    end
    timeout_limit = num_lines + 20;

    // Preload lines take no cycle
    for (int i = 0; i < num_lines; i++)
    begin
      if (stim_mem[i][79:76] == 4'h1)
      begin
        model_rf[stim_mem[i][52:48]] = stim_mem[i][31:0];
      end
    end

    repeat (reset_cycles_lp) @(posedge clk_i);
    #(drive_delay_lp);
    reset_i = 1'b0;
    running = 1'b1;

    for (int i = 0; i < num_lines; i++)
    begin
      if (stim_mem[i][79:76] == 4'h1)
      begin
        continue;
      end
      drive_line(stim_mem[i]);
      @(negedge clk_i);
      check_cycle();
      next_cycle();
    end

    // Drain the queue and idle a few cycles
    flush_i        = 1'b0;
    dispatch_pkt_i = '0;
    while (expect_q.size() > 0)
    begin
      @(negedge clk_i);
      check_cycle();
      next_cycle();
    end
    repeat (4)
    begin
      @(negedge clk_i);
      check_cycle();
      next_cycle();
    end

    $display("PASS: all tests");
    $finish;
  end

  initial
  begin
    run_cycles = 0;
    while (run_cycles <= timeout_limit)
    begin
      @(posedge clk_i);
      if (running)
      begin
        run_cycles++;
      end
    end
    stop_run("Timeout: the writebacks did not all arrive in time");
  end

endmodule

//--- dv/calc_stimulus.txt
// Columns: kind(1=preload 2=dispatch 3=flush 0=idle F=end) flush op rs1_r_v rs2_r_v rd_w_v
// then rd(2) rs1(2) rs2(2) and the expected result or preload value(8), all hex
10000001000000000005
10000002000000000003
100000030000FFFFFFF0
10000004000012345678
10000005000000000004
1000000600000000000A
00000000000000000000
00000000000000000000
20011107010200000008
20111108010200000002
20211109030412345670
2031110A01041234567D
2041110B0403EDCBA988
2051110C040523456780
2061110D03050FFFFFFF
2071110E030100000001
2071110F010300000000
20511110010600001400
20811111040548D159E0
208111120306FFFFFF60
208111130406B60B60B0
20011114010200000008
20011114141400000010
2011111514010000000B
2041111615140000001B
2001111714160000002B
2001111814150000001B
2081111902060000001E
00000000000000000000
00000000000000000000
2001111A190100000023
2011111B19020000001B
2001111C01010000000A
2001111D020200000006
2081111E01020000000F
2001111F060600000014
3101111C020200000006
2001111D1D0100000005
2081111E1C0600000064
2001111F1F1C0000000A
F0000000000000000000

//--- filelist.f
design/calc_pkg.sv
design/calc_issue.sv
design/calc_pipe_int.sv
design/calc_pipe_mul.sv
design/calc_completion.sv
design/calc_top.sv
dv/calc_tb.sv

//--- Makefile
SIM_BIN = obj_dir/Vcalc_tb

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): filelist.f design/*.sv dv/calc_tb.sv
	verilator --binary --timing --top-module calc_tb -f filelist.f -Mdir obj_dir

run: compile
	./$(SIM_BIN)

clean:
	rm -rf obj_dir
